// File: common/isaPkg.sv
`default_nettype none

package isaPkg;

	// Register file addressing
	localparam int RegIdxW = 5;

	typedef logic [RegIdxW-1:0] regIdxT;

	// HI/LO write target of a mult, div or mthi/mtlo
	typedef enum logic [1:0] {
		HiloWrLo   = 2'b00,
		HiloWrHi   = 2'b01,
		HiloWrBoth = 2'b10 // Multiply and divide write both
	} hiloWrSelT;

	// Read select of mfhi/mflo
	localparam logic hiloRdHi = 1'b1; // Zero reads LO

endpackage

`default_nettype wire

// File: common/hazardPkg.sv
`default_nettype none

package hazardPkg;

	localparam int TagW = 8;

	// Decoded instruction as it leaves ID
	typedef struct packed {
		isaPkg::regIdxT rs;
		isaPkg::regIdxT rt;
		isaPkg::regIdxT rd;
		logic regWrite;
		logic lateResult; // Load or CP0 read, value after MEM
		logic branch;
		logic hiloRead;
		logic hiloRdSel;
		logic hiloWrite;
		isaPkg::hiloWrSelT hiloWrSel;
		logic [TagW-1:0] tag;
	} decInstT;

	// One shadow stage register
	typedef struct packed {
		logic valid;
		decInstT inst;
	} stageT;

	// EX operand mux select
	typedef enum logic [1:0] {
		FwdNone = 2'b00,
		FwdMem  = 2'b01,
		FwdWb   = 2'b10
	} fwdSelT;

	// HI/LO mux select, in priority order
	typedef enum logic [2:0] {
		HiloNone   = 3'b000,
		HiloMemHi  = 3'b001,
		HiloMemLo  = 3'b010,
		HiloMemOne = 3'b011,
		HiloWbHi   = 3'b100,
		HiloWbLo   = 3'b101,
		HiloWbOne  = 3'b110
	} hiloSelT;

	typedef struct packed {
		fwdSelT exSel;
		logic brFwd;
		logic exDepLate;
		logic exDepAlu;
		logic memDepLate;
	} opFwdT;

	// Record handed out on the issue port
	typedef struct packed {
		logic [TagW-1:0] tag;
		fwdSelT rsSel;
		fwdSelT rtSel;
		logic brRsFwd;
		logic brRtFwd;
		hiloSelT hiloSel;
	} issueT;

endpackage

`default_nettype wire

// File: design/stageTrack.sv
`timescale 1ns/10ps
`default_nettype none

module stageTrack #(
	parameter int NumSrc = 2
) (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  hazardPkg::decInstT inInst,
	output logic inReady,
	input  logic hold,
	input  logic brRsFwd,
	input  logic brRtFwd,
	input  logic issueReady,
	output hazardPkg::stageT exEntry,
	output hazardPkg::stageT memEntry,
	output hazardPkg::stageT wbEntry,
	output logic [1:0] exBr,
	output isaPkg::regIdxT exSrc [NumSrc],
	output isaPkg::regIdxT idSrc [NumSrc],
	output logic idBranch
);

	logic advance;
	logic exValid;
	logic memValid;
	logic wbValid;
	hazardPkg::decInstT exInst;
	hazardPkg::decInstT memInst;
	hazardPkg::decInstT wbInst;

	// Source operand idx of an instruction, rs first
	function automatic isaPkg::regIdxT srcOf(hazardPkg::decInstT inst, int idx);
		isaPkg::regIdxT src;
		src = (idx == 0) ? inst.rs : inst.rt;
		return src;
	endfunction

	// All stages step together, EX only blocks when it cannot issue
	assign advance = issueReady || !exValid;
	assign inReady = advance && !hold; // ID held while a bubble goes in

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
			memValid <= 1'b0;
			wbValid <= 1'b0;
		end else if (advance) begin
			exValid <= inValid && !hold; // Zero here is the bubble
			memValid <= exValid;
			wbValid <= memValid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			exInst <= inInst;
			memInst <= exInst;
			wbInst <= memInst;
			exBr <= {brRtFwd, brRsFwd}; // Branch selects travel with EX
		end
	end

	assign exEntry.valid = exValid;
	assign exEntry.inst = exInst;
	assign memEntry.valid = memValid;
	assign memEntry.inst = memInst;
	assign wbEntry.valid = wbValid;
	assign wbEntry.inst = wbInst;

	// Operand indices for the per-source forwarding units
	for (genvar i = 0; i < NumSrc; i++) begin : gSrc
		assign exSrc[i] = srcOf(exInst, i);
		assign idSrc[i] = srcOf(inInst, i);
	end

	assign idBranch = inInst.branch;

endmodule

`default_nettype wire

// File: operandForward/operandForward.sv
`timescale 1ns/10ps
`default_nettype none

module operandForward (
	input  isaPkg::regIdxT exSrc,
	input  isaPkg::regIdxT idSrc,
	input  logic idBranch,
	input  hazardPkg::stageT exEntry,
	input  hazardPkg::stageT memEntry,
	input  hazardPkg::stageT wbEntry,
	output hazardPkg::opFwdT opFwd
);

	logic memWritesRd;
	logic wbWritesRd;
	logic memHitEx;
	logic wbHitEx;
	logic memHitId;

	// Producers that really write a nonzero register
	assign memWritesRd = memEntry.valid && memEntry.inst.regWrite &&
		(memEntry.inst.rd != '0);
	assign wbWritesRd = wbEntry.valid && wbEntry.inst.regWrite &&
		(wbEntry.inst.rd != '0);

	assign memHitEx = memWritesRd && (memEntry.inst.rd == exSrc);
	assign wbHitEx = wbWritesRd && (wbEntry.inst.rd == exSrc);
	assign memHitId = memWritesRd && (memEntry.inst.rd == idSrc);

	// Youngest result wins
	assign opFwd.exSel = memHitEx ? hazardPkg::FwdMem :
		(wbHitEx ? hazardPkg::FwdWb : hazardPkg::FwdNone);

	// Early compare in ID can only take the MEM result
	assign opFwd.brFwd = idBranch && memHitId;

	// Stall terms use rt as the destination and include r0
	assign opFwd.exDepLate = exEntry.valid && exEntry.inst.lateResult &&
		(exEntry.inst.rt == idSrc);
	assign opFwd.exDepAlu = exEntry.valid && exEntry.inst.regWrite &&
		(exEntry.inst.rt == idSrc);
	assign opFwd.memDepLate = memEntry.valid && memEntry.inst.lateResult &&
		(memEntry.inst.rt == idSrc);

endmodule

`default_nettype wire

// File: design/hiloForward.sv
`timescale 1ns/10ps
`default_nettype none

module hiloForward (
	input  hazardPkg::stageT exEntry,
	input  hazardPkg::stageT memEntry,
	input  hazardPkg::stageT wbEntry,
	output hazardPkg::hiloSelT hiloSel
);

	logic exReads;
	logic rdHi;
	logic memWr;
	logic wbWr;
	logic memBoth;
	logic wbBoth;
	logic memOne;
	logic wbOne;

	assign exReads = exEntry.valid && exEntry.inst.hiloRead;
	assign rdHi = (exEntry.inst.hiloRdSel == isaPkg::hiloRdHi);

	assign memWr = memEntry.valid && memEntry.inst.hiloWrite;
	assign wbWr = wbEntry.valid && wbEntry.inst.hiloWrite;

	assign memBoth = memWr && (memEntry.inst.hiloWrSel == isaPkg::HiloWrBoth);
	assign wbBoth = wbWr && (wbEntry.inst.hiloWrSel == isaPkg::HiloWrBoth);

	// Single HI or LO write matching the read side
	assign memOne = memWr && (memEntry.inst.hiloWrSel != isaPkg::HiloWrBoth) &&
		(memEntry.inst.hiloWrSel[0] == exEntry.inst.hiloRdSel);
	assign wbOne = wbWr && (wbEntry.inst.hiloWrSel != isaPkg::HiloWrBoth) &&
		(wbEntry.inst.hiloWrSel[0] == exEntry.inst.hiloRdSel);

	always_comb begin
		hiloSel = hazardPkg::HiloNone;
		if (exReads) begin
			if (memBoth && rdHi) hiloSel = hazardPkg::HiloMemHi;
			else if (memBoth) hiloSel = hazardPkg::HiloMemLo;
			else if (memOne) hiloSel = hazardPkg::HiloMemOne;
			else if (wbBoth && rdHi) hiloSel = hazardPkg::HiloWbHi;
			else if (wbBoth) hiloSel = hazardPkg::HiloWbLo;
			else if (wbOne) hiloSel = hazardPkg::HiloWbOne;
		end
	end

endmodule

`default_nettype wire

// File: design/stallDetect.sv
`timescale 1ns/10ps
`default_nettype none

module stallDetect #(
	parameter int NumSrc = 2
) (
	input  hazardPkg::opFwdT opFwd [NumSrc],
	input  logic idValid,
	input  logic idBranch,
	output logic hold,
	output logic brRsFwd,
	output logic brRtFwd
);

	logic [NumSrc-1:0] srcHazard;

	// Per operand, any of the three stall cases
	always_comb begin
		for (int i = 0; i < NumSrc; i++) begin
			srcHazard[i] = opFwd[i].exDepLate ||
				(idBranch && opFwd[i].memDepLate) || // Load result too late for compare
				(idBranch && opFwd[i].exDepAlu);     // ALU result not yet in MEM
		end
	end

	assign hold = idValid && (|srcHazard);

	// Early compare muxes, rs then rt
	assign brRsFwd = opFwd[0].brFwd;
	assign brRtFwd = opFwd[1].brFwd;

endmodule

`default_nettype wire

// File: design/hazardTop.sv
`timescale 1ns/10ps
`default_nettype none

module hazardTop #(
	parameter int NumSrc = 2
) (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  hazardPkg::decInstT inInst,
	output logic inReady,
	output logic issueValid,
	output hazardPkg::issueT issue,
	input  logic issueReady
);

	hazardPkg::stageT exEntry;
	hazardPkg::stageT memEntry;
	hazardPkg::stageT wbEntry;
	hazardPkg::opFwdT opFwd [NumSrc];
	hazardPkg::hiloSelT hiloSel;
	isaPkg::regIdxT exSrc [NumSrc];
	isaPkg::regIdxT idSrc [NumSrc];
	logic idBranch;
	logic hold;
	logic brRsFwd;
	logic brRtFwd;
	logic [1:0] exBr;

	stageTrack #(.NumSrc(NumSrc)) stageTrack0 (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inInst(inInst),
		.inReady(inReady),
		.hold(hold),
		.brRsFwd(brRsFwd),
		.brRtFwd(brRtFwd),
		.issueReady(issueReady),
		.exEntry(exEntry),
		.memEntry(memEntry),
		.wbEntry(wbEntry),
		.exBr(exBr),
		.exSrc(exSrc),
		.idSrc(idSrc),
		.idBranch(idBranch)
	);

	// One forwarding unit per source operand
	for (genvar i = 0; i < NumSrc; i++) begin : gFwd
		operandForward operandForward0 (
			.exSrc(exSrc[i]),
			.idSrc(idSrc[i]),
			.idBranch(idBranch),
			.exEntry(exEntry),
			.memEntry(memEntry),
			.wbEntry(wbEntry),
			.opFwd(opFwd[i])
		);
	end

	stallDetect #(.NumSrc(NumSrc)) stallDetect0 (
		.opFwd(opFwd),
		.idValid(inValid),
		.idBranch(idBranch),
		.hold(hold),
		.brRsFwd(brRsFwd),
		.brRtFwd(brRtFwd)
	);

	hiloForward hiloForward0 (
		.exEntry(exEntry),
		.memEntry(memEntry),
		.wbEntry(wbEntry),
		.hiloSel(hiloSel)
	);

	assign issueValid = exEntry.valid; // Bubbles never issue
	assign issue.tag = exEntry.inst.tag;
	assign issue.rsSel = opFwd[0].exSel;
	assign issue.rtSel = opFwd[1].exSel;
	assign issue.brRsFwd = exBr[0]; // Captured while in ID
	assign issue.brRtFwd = exBr[1];
	assign issue.hiloSel = hiloSel;

endmodule

`default_nettype wire

// File: verif/hazardChecker.sv
`timescale 1ns/10ps
`default_nettype none

module hazardChecker (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  logic inReady,
	input  hazardPkg::issueT expectIssue,
	input  logic issueValid,
	input  logic issueReady,
	input  hazardPkg::issueT issue,
	output int errorCount,
	output int issuedCount,
	output int pendingCount
);

	hazardPkg::issueT expectQ [$]; // Accepted and not yet issued
	hazardPkg::issueT heldIssue;
	logic wasStalled;
	logic lastAccept;
	logic [hazardPkg::TagW-1:0] lastTag;
	int errors = 0;
	int issued = 0;

	// One field of an issued record against its expected value
	task automatic compareField(input string name, input int got, input int want,
		input logic [7:0] tag);
		if (got != want) begin
			$display("FAILED %0t: tag %h field %s is %0d, expected %0d",
				$time, tag, name, got, want);
			errors++;
		end
	endtask

	always @(posedge clk or negedge arstN) begin
		hazardPkg::issueT want;
		if (!arstN) begin
			expectQ.delete();
			wasStalled <= 1'b0;
			lastAccept <= 1'b0;
		end else begin
			if (inValid && inReady) begin
				expectQ.push_back(expectIssue);
			end
			// An accepted instruction sits in EX one edge later
			if (lastAccept && (!issueValid || issue.tag != lastTag)) begin
				$display("Tag %h was accepted but is not in EX at %0t", lastTag, $time);
				errors++;
			end
			// Issue record must hold while the consumer is not ready
			if (wasStalled && (!issueValid || issue != heldIssue)) begin
				$display("Issue record changed at %0t while the issue port was stalled", $time);
				errors++;
			end
			if (issueValid && issueReady) begin
				issued++;
				if (expectQ.size() == 0) begin
					$display("Tag %h issued at %0t with no accepted instruction left",
						issue.tag, $time);
					errors++;
				end else begin
					want = expectQ.pop_front();
					if (issue.tag != want.tag) begin
						$display("Tag %h issued at %0t out of order, tag %h was due next",
							issue.tag, $time, want.tag);
						errors++;
					end else begin
						compareField("rsSel", issue.rsSel, want.rsSel, want.tag);
						compareField("rtSel", issue.rtSel, want.rtSel, want.tag);
						compareField("brRsFwd", issue.brRsFwd, want.brRsFwd, want.tag);
						compareField("brRtFwd", issue.brRtFwd, want.brRtFwd, want.tag);
						compareField("hiloSel", issue.hiloSel, want.hiloSel, want.tag);
					end
				end
			end
			wasStalled <= issueValid && !issueReady;
			heldIssue <= issue;
			lastAccept <= inValid && inReady;
			lastTag <= expectIssue.tag;
		end
		errorCount <= errors;
		issuedCount <= issued;
		pendingCount <= expectQ.size();
	end

endmodule

`default_nettype wire

// File: verif/hazardTb.sv
`timescale 1ns/10ps
`default_nettype none

module hazardTb;

	localparam int NumCols = 16;
	localparam int MaxVecs = 128;
	localparam int ResetCycles = 8;

	logic clk;
	logic arstN;
	logic inValid;
	hazardPkg::decInstT inInst;
	logic inReady;
	logic issueValid;
	hazardPkg::issueT issue;
	logic issueReady;
	hazardPkg::issueT expectIssue;
	logic backPressure;

	logic [7:0] vecMem [MaxVecs * NumCols];
	int vecCount;
	int sendIdx;
	int cycleCount;
	int cycleLimit;
	int errorCount;
	int issuedCount;
	int pendingCount;

	// Decoded instruction from columns 0 to 10 of one line
	function automatic hazardPkg::decInstT instOf(int idx);
		hazardPkg::decInstT inst;
		int base;
		base = idx * NumCols;
		inst.rs = vecMem[base][4:0];
		inst.rt = vecMem[base + 1][4:0];
		inst.rd = vecMem[base + 2][4:0];
		inst.regWrite = vecMem[base + 3][0];
		inst.lateResult = vecMem[base + 4][0];
		inst.branch = vecMem[base + 5][0];
		inst.hiloRead = vecMem[base + 6][0];
		inst.hiloRdSel = vecMem[base + 7][0];
		inst.hiloWrite = vecMem[base + 8][0];
		inst.hiloWrSel = isaPkg::hiloWrSelT'(vecMem[base + 9][1:0]);
		inst.tag = vecMem[base + 10];
		return inst;
	endfunction

	// Expected issue record from the tag and columns 11 to 15
	function automatic hazardPkg::issueT expectOf(int idx);
		hazardPkg::issueT want;
		int base;
		base = idx * NumCols;
		want.tag = vecMem[base + 10];
		want.rsSel = hazardPkg::fwdSelT'(vecMem[base + 11][1:0]);
		want.rtSel = hazardPkg::fwdSelT'(vecMem[base + 12][1:0]);
		want.brRsFwd = vecMem[base + 13][0];
		want.brRtFwd = vecMem[base + 14][0];
		want.hiloSel = hazardPkg::hiloSelT'(vecMem[base + 15][2:0]);
		return want;
	endfunction

	hazardTop #(.NumSrc(2)) dut0 (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inInst(inInst),
		.inReady(inReady),
		.issueValid(issueValid),
		.issue(issue),
		.issueReady(issueReady)
	);

	hazardChecker checker0 (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.expectIssue(expectIssue),
		.issueValid(issueValid),
		.issueReady(issueReady),
		.issue(issue),
		.errorCount(errorCount),
		.issuedCount(issuedCount),
		.pendingCount(pendingCount)
	);

	always #10 clk = ~clk;

	// Random back-pressure on the issue port
	initial begin
		void'($urandom(32'h40c3));
		issueReady = 1'b1;
		forever begin
			@(posedge clk);
			if (backPressure) begin
				issueReady <= ($urandom % 100) >= 30; // Low about 30% of cycles
			end else begin
				issueReady <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, only %0d of %0d instructions issued",
				cycleCount, issuedCount, vecCount);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		inInst = '0;
		expectIssue = '0;
		backPressure = 1'b0;
		sendIdx = 0;
		cycleCount = 0;
		for (int i = 0; i < MaxVecs * NumCols; i++) begin
			vecMem[i] = 8'hff; // Unused lines keep an rs of ff
		end
		$readmemh("verif/hazardVectors.txt", vecMem);
		vecCount = 0;
		while (vecCount < MaxVecs && vecMem[vecCount * NumCols] != 8'hff) begin
			vecCount++;
		end
		cycleLimit = (4 * vecCount + ResetCycles) * 3;
		repeat (ResetCycles) @(posedge clk);
		arstN <= 1'b1;
		@(posedge clk);
		while (sendIdx < vecCount) begin
			inValid <= 1'b1; // Kept high so bubbles follow the program only
			inInst <= instOf(sendIdx);
			expectIssue <= expectOf(sendIdx);
			if (sendIdx >= vecCount / 2) begin
				backPressure <= 1'b1;
			end
			@(posedge clk);
			while (!inReady) @(posedge clk);
			sendIdx++;
		end
		inValid <= 1'b0;
		while (issuedCount < vecCount) @(posedge clk);
		repeat (4) @(posedge clk); // Room for a stray extra issue
		if (vecCount == 0) begin
			$display("No vectors were read from verif/hazardVectors.txt");
		end
		$display("Issued %0d of %0d instructions, %0d pending, %0d errors",
			issuedCount, vecCount, pendingCount, errorCount);
		if (errorCount == 0 && vecCount > 0 && pendingCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/hazardVectors.txt
// rs rt rd regWrite lateResult branch hiloRead hiloRdSel hiloWrite hiloWrSel tag
// then expected: rsSel rtSel brRsFwd brRtFwd hiloSel
02 03 01 1 0 0 0 0 0 0 01  0 0 0 0 0 // ALU forwarding, MEM over WB
05 06 04 1 0 0 0 0 0 0 02  0 0 0 0 0
01 04 07 1 0 0 0 0 0 0 03  2 1 0 0 0
02 03 08 1 0 0 0 0 0 0 04  0 0 0 0 0
05 06 08 1 0 0 0 0 0 0 05  0 0 0 0 0
08 08 09 1 0 0 0 0 0 0 06  1 1 0 0 0
02 03 00 1 0 0 0 0 0 0 07  0 0 0 0 0 // Write to r0
00 09 0a 1 0 0 0 0 0 0 08  0 2 0 0 0
02 0b 0b 1 1 0 0 0 0 0 09  0 0 0 0 0 // Load use, one bubble each
0b 03 0c 1 0 0 0 0 0 0 0a  2 0 0 0 0
05 0e 0e 1 1 0 0 0 0 0 0b  0 0 0 0 0
06 0e 0f 1 0 0 0 0 0 0 0c  0 2 0 0 0
02 10 10 1 1 0 0 0 0 0 0d  0 0 0 0 0
02 03 11 1 0 0 0 0 0 0 0e  0 0 0 0 0
10 11 12 1 0 0 0 0 0 0 0f  2 1 0 0 0
02 13 13 1 0 0 0 0 0 0 10  0 0 0 0 0 // Branch after ALU in EX
13 05 00 0 0 1 0 0 0 0 11  2 0 1 0 0
02 14 14 1 0 0 0 0 0 0 12  0 0 0 0 0
05 06 15 1 0 0 0 0 0 0 13  0 0 0 0 0
05 14 00 0 0 1 0 0 0 0 14  0 2 0 1 0
02 16 16 1 1 0 0 0 0 0 15  0 0 0 0 0 // Branch on load two back
05 06 17 1 0 0 0 0 0 0 16  0 0 0 0 0
16 00 00 0 0 1 0 0 0 0 17  0 0 0 0 0
02 18 18 1 1 0 0 0 0 0 18  0 0 0 0 0 // Branch right after load, two bubbles
05 18 00 0 0 1 0 0 0 0 19  0 0 0 0 0
02 00 19 1 0 0 0 0 0 0 1a  0 0 0 0 0 // rt of r0 still stalls
00 03 00 0 0 1 0 0 0 0 1b  0 0 0 0 0
02 03 00 0 0 0 0 0 1 2 1c  0 0 0 0 0 // HI/LO pairs
00 00 1a 1 0 0 1 1 0 0 1d  0 0 0 0 1
02 03 00 0 0 0 0 0 1 2 1e  0 0 0 0 0
00 00 1b 1 0 0 1 0 0 0 1f  0 0 0 0 2
02 00 00 0 0 0 0 0 1 1 20  0 0 0 0 0
00 00 1c 1 0 0 1 1 0 0 21  0 0 0 0 3
02 03 00 0 0 0 0 0 1 2 22  0 0 0 0 0
00 00 00 0 0 0 0 0 0 0 23  0 0 0 0 0
00 00 1d 1 0 0 1 1 0 0 24  0 0 0 0 4
02 03 00 0 0 0 0 0 1 2 25  0 0 0 0 0
00 00 00 0 0 0 0 0 0 0 26  0 0 0 0 0
00 00 1e 1 0 0 1 0 0 0 27  0 0 0 0 5
02 00 00 0 0 0 0 0 1 0 28  0 0 0 0 0
00 00 00 0 0 0 0 0 0 0 29  0 0 0 0 0
00 00 1f 1 0 0 1 0 0 0 2a  0 0 0 0 6
02 00 00 0 0 0 0 0 1 1 2b  0 0 0 0 0
00 00 1a 1 0 0 1 0 0 0 2c  0 0 0 0 0 // HI written, LO read
02 0b 0b 1 1 0 0 0 0 0 2d  0 0 0 0 0
0b 0b 0c 1 0 0 0 0 0 0 2e  2 2 0 0 0
0c 0b 00 0 0 1 0 0 0 0 2f  2 0 1 0 0

// File: filelist.f
common/isaPkg.sv
common/hazardPkg.sv
design/stageTrack.sv
operandForward/operandForward.sv
design/hiloForward.sv
design/stallDetect.sv
design/hazardTop.sv
verif/hazardChecker.sv
verif/hazardTb.sv

// File: Bender.yml
package:
  name: hazard_ctrl

sources:
  - common/isaPkg.sv
  - common/hazardPkg.sv
  - design/stageTrack.sv
  - operandForward/operandForward.sv
  - design/hiloForward.sv
  - design/stallDetect.sv
  - design/hazardTop.sv
  - target: test
    files:
      - verif/hazardChecker.sv
      - verif/hazardTb.sv
